/* axi_skid_buffer.sv */
`timescale 1ns/1ns

module axi_skid_buffer #(
    parameter int SKID_DEPTH = 2
) (
    input  logic                   i_axi_aclk,
    input  logic                   i_axi_aresetn,

    // Write side
    input  logic                   i_wr_valid,
    output logic                   o_wr_ready,
    input  stream_pkg::t_axis_beat i_wr_beat,

    // Read side
    output logic                   o_rd_valid,
    input  logic                   i_rd_ready,
    output logic [3:0]             o_rd_count,
    output stream_pkg::t_axis_beat o_rd_beat
);

    import stream_pkg::*;

    t_axis_beat r_slot  [SKID_DEPTH];
    t_axis_beat w_shift [SKID_DEPTH];
    logic [3:0] r_count;
    logic [3:0] w_wr_idx;
    logic       w_wr_xfer;
    logic       w_rd_xfer;

    assign w_wr_xfer = i_wr_valid & o_wr_ready;
    assign w_rd_xfer = o_rd_valid & i_rd_ready;

    // A read frees slot 0, so the new beat lands one slot lower
    assign w_wr_idx = w_rd_xfer ? (r_count - 4'd1) : r_count;

    // Contents after a read, top slot keeps its old value
    always_comb begin
        for (int i = 0; i < SKID_DEPTH - 1; i++) begin
            w_shift[i] = r_slot[i + 1];
        end
        w_shift[SKID_DEPTH-1] = r_slot[SKID_DEPTH-1];
    end

    always_ff @(posedge i_axi_aclk) begin
        for (int i = 0; i < SKID_DEPTH; i++) begin
            if (w_wr_xfer && (w_wr_idx == i)) begin
                r_slot[i] <= i_wr_beat;
            end else if (w_rd_xfer) begin
                r_slot[i] <= w_shift[i];
            end
        end
    end

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            r_count <= 4'd0;
        end else if (w_wr_xfer && !w_rd_xfer) begin
            r_count <= r_count + 4'd1;
        end else if (!w_wr_xfer && w_rd_xfer) begin
            r_count <= r_count - 4'd1;
        end
    end

    // Flags look one cycle ahead using this cycle's transfers
    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            o_wr_ready <= 1'b0;
            o_rd_valid <= 1'b0;
        end else begin
            o_wr_ready <= (r_count <= SKID_DEPTH - 2) ||
                          (r_count == SKID_DEPTH - 1 && (!w_wr_xfer || w_rd_xfer)) ||
                          (r_count == SKID_DEPTH && w_rd_xfer);
            o_rd_valid <= (r_count >= 4'd2) ||
                          (r_count == 4'd1 && (!w_rd_xfer || w_wr_xfer)) ||
                          (r_count == 4'd0 && w_wr_xfer);
        end
    end

    assign o_rd_beat  = r_slot[0];
    assign o_rd_count = r_count;

endmodule : axi_skid_buffer

/* axis_byte_order.sv */
`timescale 1ns/1ns

`include "stream_settings.svh"

module axis_byte_order (
    input  logic                   i_axi_aclk,
    input  logic                   i_axi_aresetn,

    // Upstream side
    input  logic                   i_valid,
    output logic                   o_ready,
    input  stream_pkg::t_axis_beat i_beat,

    // Level control, sampled at packet start
    input  logic                   i_swap_en,

    // Downstream side
    output logic                   o_valid,
    input  logic                   i_ready,
    output stream_pkg::t_axis_beat o_beat
);

    import stream_pkg::*;

    localparam int NUM_BYTES = `STREAM_DATA_WIDTH / 8;

    logic [`STREAM_DATA_WIDTH-1:0] w_swapped;
    logic                          w_in_xfer;
    logic                          w_swap_now;
    logic                          r_in_pkt;
    logic                          r_swap_sel;

    // Stage accepts when empty or when its beat leaves this cycle
    assign o_ready   = !o_valid || i_ready;
    assign w_in_xfer = i_valid && o_ready;

    // First beat uses the live input, later beats the latched choice
    assign w_swap_now = r_in_pkt ? r_swap_sel : i_swap_en;

    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            w_swapped[b*8 +: 8] = i_beat.data[(NUM_BYTES-1-b)*8 +: 8];
        end
    end

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            o_valid    <= 1'b0;
            r_in_pkt   <= 1'b0;
            r_swap_sel <= 1'b0;
        end else begin
            if (w_in_xfer) begin
                o_valid  <= 1'b1;
                r_in_pkt <= !i_beat.last;
                if (!r_in_pkt) begin
                    r_swap_sel <= i_swap_en;
                end
            end else if (i_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

    // Last flag is never touched by the swap
    always_ff @(posedge i_axi_aclk) begin
        if (w_in_xfer) begin
            o_beat.data <= w_swap_now ? w_swapped : i_beat.data;
            o_beat.last <= i_beat.last;
        end
    end

endmodule : axis_byte_order

/* axis_pkt_monitor.sv */
`timescale 1ns/1ns

`include "stream_settings.svh"

module axis_pkt_monitor (
    input  logic                         i_axi_aclk,
    input  logic                         i_axi_aresetn,

    // Observed handshake, no influence on the stream
    input  logic                         i_valid,
    input  logic                         i_ready,
    input  logic                         i_last,

    // Running totals, wrapping at full scale
    output logic [`STREAM_CNT_WIDTH-1:0] o_pkt_count,
    output logic [`STREAM_CNT_WIDTH-1:0] o_beat_count
);

    logic w_xfer;

    assign w_xfer = i_valid && i_ready;

    // Every transfer is a beat
    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            o_beat_count <= '0;
        end else if (w_xfer) begin
            o_beat_count <= o_beat_count + 1'b1;
        end
    end

    // A packet completes on the beat carrying last
    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            o_pkt_count <= '0;
        end else if (w_xfer && i_last) begin
            o_pkt_count <= o_pkt_count + 1'b1;
        end
    end

endmodule : axis_pkt_monitor

/* axis_stream_path.sv */
`timescale 1ns/1ns

`include "stream_settings.svh"

module axis_stream_path (
    input  logic                         i_axi_aclk,
    input  logic                         i_axi_aresetn,

    // Input stream
    input  logic                         i_in_valid,
    output logic                         o_in_ready,
    input  stream_pkg::t_axis_beat       i_in_beat,

    // Byte order select, level
    input  logic                         i_swap_en,

    // Output stream
    output logic                         o_out_valid,
    input  logic                         i_out_ready,
    output stream_pkg::t_axis_beat       o_out_beat,

    // Status
    output logic [3:0]                   o_in_fill,
    output logic [`STREAM_CNT_WIDTH-1:0] o_pkt_count,
    output logic [`STREAM_CNT_WIDTH-1:0] o_beat_count
);

    import stream_pkg::*;

    // Input buffer to byte-order stage
    logic       s1_valid;
    logic       s1_ready;
    t_axis_beat s1_beat;

    // Byte-order stage to output buffer
    logic       s2_valid;
    logic       s2_ready;
    t_axis_beat s2_beat;

    axi_skid_buffer #(
        .SKID_DEPTH (`STREAM_IN_SKID_DEPTH)
    ) in_skid_i (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_wr_valid    (i_in_valid),
        .o_wr_ready    (o_in_ready),
        .i_wr_beat     (i_in_beat),
        .o_rd_valid    (s1_valid),
        .i_rd_ready    (s1_ready),
        .o_rd_count    (o_in_fill),
        .o_rd_beat     (s1_beat)
    );

    axis_byte_order byte_order_i (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_valid       (s1_valid),
        .o_ready       (s1_ready),
        .i_beat        (s1_beat),
        .i_swap_en     (i_swap_en),
        .o_valid       (s2_valid),
        .i_ready       (s2_ready),
        .o_beat        (s2_beat)
    );

    // Occupancy of the output buffer is not reported
    axi_skid_buffer #(
        .SKID_DEPTH (`STREAM_OUT_SKID_DEPTH)
    ) out_skid_i (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_wr_valid    (s2_valid),
        .o_wr_ready    (s2_ready),
        .i_wr_beat     (s2_beat),
        .o_rd_valid    (o_out_valid),
        .i_rd_ready    (i_out_ready),
        .o_rd_count    (),
        .o_rd_beat     (o_out_beat)
    );

    axis_pkt_monitor monitor_i (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_valid       (o_out_valid),
        .i_ready       (i_out_ready),
        .i_last        (o_out_beat.last),
        .o_pkt_count   (o_pkt_count),
        .o_beat_count  (o_beat_count)
    );

endmodule : axis_stream_path

/* axis_stream_stim.txt */
# T <test number> <ready percent> | I <data hex> <last> <swap_en>
# E <expected data hex> <expected last> | C <packet count> <beat count>
# Pass-through, swap off, sink always ready
T 1 100
I 11223344 0 0
I 55667788 0 0
I 99aabbcc 0 0
I ddeeff00 1 0
I 01020304 0 0
I 05060708 0 0
I 090a0b0c 1 0
I cafe0001 1 0
E 11223344 0
E 55667788 0
E 99aabbcc 0
E ddeeff00 1
E 01020304 0
E 05060708 0
E 090a0b0c 1
E cafe0001 1
# Byte reversal on every beat
T 2 100
I a1b2c3d4 0 1
I 0badf00d 0 1
I 12345678 1 1
I deadbeef 0 1
I 87654321 1 1
E d4c3b2a1 0
E 0df0ad0b 0
E 78563412 1
E efbeadde 0
E 21436587 1
# Swap toggled inside packets, first beat decides
T 3 100
I 10203040 0 0
I 50607080 0 0
I 90a0b0c0 0 1
I d0e0f000 1 1
I 13579bdf 0 1
I 2468ace0 0 1
I fedcba98 1 0
I 00ff00ff 0 0
I 76543210 1 0
E 10203040 0
E 50607080 0
E 90a0b0c0 0
E d0e0f000 1
E df9b5713 0
E e0ac6824 0
E 98badcfe 1
E 00ff00ff 0
E 76543210 1
# Back-pressure, sink ready 30 percent
T 4 30
I a0000001 0 0
I a0000102 0 0
I a0010203 0 0
I a1020304 0 0
I b2030405 0 0
I c3040506 1 0
I d1d2d3d4 0 0
I e1e2e3e4 0 0
I f1f2f3f4 0 0
I 1a2b3c4d 1 0
I 5e6f7a8b 0 0
I 9cadbecf 0 0
I 01234567 0 0
I 89abcdef 0 0
I 76fe54dc 1 0
I 3c3c5a5a 1 0
E a0000001 0
E a0000102 0
E a0010203 0
E a1020304 0
E b2030405 0
E c3040506 1
E d1d2d3d4 0
E e1e2e3e4 0
E f1f2f3f4 0
E 1a2b3c4d 1
E 5e6f7a8b 0
E 9cadbecf 0
E 01234567 0
E 89abcdef 0
E 76fe54dc 1
E 3c3c5a5a 1
# Long stalls, sink ready 10 percent, swap on
T 5 10
I 0a0b0c0d 0 1
I 1f2e3d4c 0 1
I 55aa33cc 1 1
I 80000001 0 1
I 7fffff00 0 1
I 12ab34cd 0 1
I 6789abcd 0 1
I f00dface 1 1
I 3344ccdd 0 1
I 9a8b7c6d 0 1
I e5d4c3b2 0 1
I 4a5b6c7d 1 1
E 0d0c0b0a 0
E 4c3d2e1f 0
E cc33aa55 1
E 01000080 0
E 00ffff7f 0
E cd34ab12 0
E cdab8967 0
E cefa0df0 1
E ddcc4433 0
E 6d7c8b9a 0
E b2c3d4e5 0
E 7d6c5b4a 1
# Totals over all tests
C 15 50

/* filelist.f */
+incdir+.
stream_pkg.sv
axi_skid_buffer.sv
axis_byte_order.sv
axis_pkt_monitor.sv
axis_stream_path.sv
tb_axis_stream_path.sv

/* stream_pkg.sv */
`include "stream_settings.svh"

package stream_pkg;

    // One AXI-Stream beat as it moves through the data path
    // Payload in the upper bits, end-of-packet marker in bit 0
    typedef struct packed {
        logic [`STREAM_DATA_WIDTH-1:0] data;
        logic                          last;
    } t_axis_beat;

endpackage : stream_pkg

/* stream_settings.svh */
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// Beat payload width, a whole number of bytes
`define STREAM_DATA_WIDTH 32

// Skid buffer depths, each one of 2, 4, 6 or 8
`define STREAM_IN_SKID_DEPTH 4
`define STREAM_OUT_SKID_DEPTH 2

// Packet and beat counter width in the monitor
`define STREAM_CNT_WIDTH 16

`endif

/* tb_axis_stream_path.sv */
`timescale 1ns/1ns

`include "stream_settings.svh"

module tb_axis_stream_path;

    import stream_pkg::*;

    logic                         i_axi_aclk;
    logic                         i_axi_aresetn;
    logic                         i_in_valid;
    logic                         o_in_ready;
    t_axis_beat                   i_in_beat;
    logic                         i_swap_en;
    logic                         o_out_valid;
    logic                         i_out_ready;
    t_axis_beat                   o_out_beat;
    logic [3:0]                   o_in_fill;
    logic [`STREAM_CNT_WIDTH-1:0] o_pkt_count;
    logic [`STREAM_CNT_WIDTH-1:0] o_beat_count;

    // Stimulus and expected beats as read from the stim file
    logic [31:0] in_data  [$];
    logic        in_last  [$];
    logic        in_swap  [$];
    logic [31:0] exp_data [$];
    logic        exp_last [$];
    integer      test_num [$];
    integer      test_pct [$];
    // Index of each test's first beat plus one extra entry past the end
    integer      test_in_first  [$];
    integer      test_exp_first [$];
    integer      exp_pkts;
    integer      exp_beats;

    integer seed;
    integer sink_pct     = 0;
    integer exp_idx      = 0;
    integer cur_exp_end  = 0;
    integer stall_cycles = 0;
    integer err_count    = 0;
    integer tests_passed = 0;
    integer tests_failed = 0;
    integer cycle_cnt    = 0;
    integer cycle_limit  = 0;

    axis_stream_path dut_i (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_in_valid    (i_in_valid),
        .o_in_ready    (o_in_ready),
        .i_in_beat     (i_in_beat),
        .i_swap_en     (i_swap_en),
        .o_out_valid   (o_out_valid),
        .i_out_ready   (i_out_ready),
        .o_out_beat    (o_out_beat),
        .o_in_fill     (o_in_fill),
        .o_pkt_count   (o_pkt_count),
        .o_beat_count  (o_beat_count)
    );

    always #4 i_axi_aclk = ~i_axi_aclk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("error %s: got %0h, expected %0h", name, got, expected);
            err_count = err_count + 1;
        end
    endtask

    // Line tags are # comment, T test header, I input beat, E expected beat, C final counts
    task automatic read_stim(output bit ok);
        integer       fd;
        integer       rc;
        integer       a;
        integer       b;
        bit           done;
        logic [63:0]  tag;
        logic [959:0] text;
        logic [31:0]  data;
        ok   = 1'b0;
        done = 1'b0;
        fd   = $fopen("axis_stream_stim.txt", "r");
        if (fd != 0) begin
            while (!done) begin
                rc = $fscanf(fd, "%s", tag);
                if (rc != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    rc = $fgets(text, fd);
                end else if (tag == "T") begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    test_num.push_back(a);
                    test_pct.push_back(b);
                    test_in_first.push_back(in_data.size());
                    test_exp_first.push_back(exp_data.size());
                end else if (tag == "I") begin
                    rc = $fscanf(fd, "%h %d %d", data, a, b);
                    in_data.push_back(data);
                    in_last.push_back(a[0]);
                    in_swap.push_back(b[0]);
                end else if (tag == "E") begin
                    rc = $fscanf(fd, "%h %d", data, a);
                    exp_data.push_back(data);
                    exp_last.push_back(a[0]);
                end else if (tag == "C") begin
                    rc = $fscanf(fd, "%d %d", a, b);
                    exp_pkts  = a;
                    exp_beats = b;
                    ok        = 1'b1;
                end else begin
                    $display("stim file holds a line with an unknown tag");
                    ok   = 1'b0;
                    done = 1'b1;
                end
            end
            $fclose(fd);
            test_in_first.push_back(in_data.size());
            test_exp_first.push_back(exp_data.size());
        end
    endtask

    task automatic run_test(input integer t);
        integer     i;
        integer     err_before;
        integer     stall_before;
        t_axis_beat beat;
        err_before   = err_count;
        stall_before = stall_cycles;
        sink_pct    <= test_pct[t];
        cur_exp_end <= test_exp_first[t+1];
        for (i = test_in_first[t]; i < test_in_first[t+1]; i++) begin
            beat.data = in_data[i];
            beat.last = in_last[i];
            i_in_valid <= 1'b1;
            i_in_beat  <= beat;
            i_swap_en  <= in_swap[i];
            // Hold the beat until the input side takes it
            do begin
                @(posedge i_axi_aclk);
            end while (!o_in_ready);
        end
        i_in_valid <= 1'b0;
        while (exp_idx < test_exp_first[t+1]) begin
            @(posedge i_axi_aclk);
        end
        repeat (2) @(posedge i_axi_aclk);
        // Low ready rates must back the pipeline up to the input
        if (test_pct[t] < 50 && stall_cycles == stall_before) begin
            $display("input ready never fell while test %0d was stalled", test_num[t]);
            err_count = err_count + 1;
        end
        if (err_count == err_before) begin
            tests_passed = tests_passed + 1;
        end else begin
            tests_failed = tests_failed + 1;
        end
        $display("test %0d, ready %0d%%: %s, %0d beats in, %0d errors", test_num[t],
                 test_pct[t], (err_count == err_before) ? "pass" : "fail",
                 test_in_first[t+1] - test_in_first[t], err_count - err_before);
    endtask

    // Sink with output checks and fill bound
    always @(posedge i_axi_aclk) begin
        i_out_ready <= ({$random(seed)} % 100) < sink_pct;
        if (i_axi_aresetn && i_in_valid && !o_in_ready) begin
            stall_cycles <= stall_cycles + 1;
            // Input ready only drops once the input buffer is full
            check_value("o_in_fill", o_in_fill, `STREAM_IN_SKID_DEPTH);
        end
        if (o_in_fill > `STREAM_IN_SKID_DEPTH) begin
            $display("error o_in_fill: got %0h, above the depth %0h", o_in_fill,
                     `STREAM_IN_SKID_DEPTH);
            err_count = err_count + 1;
        end
        if (o_out_valid && i_out_ready) begin
            if (exp_idx >= cur_exp_end) begin
                $display("output beat %0h arrived with no expected beat left",
                         o_out_beat.data);
                err_count = err_count + 1;
            end else begin
                check_value("o_out_beat.data", o_out_beat.data, exp_data[exp_idx]);
                check_value("o_out_beat.last", o_out_beat.last, exp_last[exp_idx]);
            end
            exp_idx <= exp_idx + 1;
        end
    end

    always @(posedge i_axi_aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin : main_seq
        bit     stim_ok;
        integer t;
        integer err_before;
        i_axi_aclk    = 1'b0;
        i_axi_aresetn = 1'b0;
        i_in_valid    = 1'b0;
        i_in_beat     = '0;
        i_swap_en     = 1'b0;
        i_out_ready   = 1'b0;
        seed          = 32'hd15d2030;
        read_stim(stim_ok);
        if (!stim_ok) begin
            $display("could not read a complete stimulus file");
            $display("=== FAIL ===");
            $finish;
        end else begin
            cycle_limit = 20 * in_data.size() + 100;
            err_before  = err_count;
            // Outputs sampled mid-cycle while reset is held
            repeat (3) begin
                @(negedge i_axi_aclk);
                check_value("o_out_valid", o_out_valid, 0);
                check_value("o_in_ready", o_in_ready, 0);
                check_value("o_in_fill", o_in_fill, 0);
                check_value("o_pkt_count", o_pkt_count, 0);
                check_value("o_beat_count", o_beat_count, 0);
            end
            @(posedge i_axi_aclk);
            i_axi_aresetn <= 1'b1;
            repeat (2) @(posedge i_axi_aclk);
            if (err_count == err_before) begin
                tests_passed = tests_passed + 1;
            end else begin
                tests_failed = tests_failed + 1;
            end
            $display("reset state: %0d errors", err_count - err_before);

            for (t = 0; t < test_num.size(); t++) begin
                run_test(t);
            end

            err_before = err_count;
            check_value("o_pkt_count", o_pkt_count, exp_pkts);
            check_value("o_beat_count", o_beat_count, exp_beats);
            if (err_count == err_before) begin
                tests_passed = tests_passed + 1;
            end else begin
                tests_failed = tests_failed + 1;
            end
            $display("counters: %0d packets, %0d beats, %0d errors", o_pkt_count,
                     o_beat_count, err_count - err_before);

            $display("tests passed %0d, failed %0d, errors %0d", tests_passed,
                     tests_failed, err_count);
            if (err_count == 0 && tests_failed == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule : tb_axis_stream_path
